// File: hdl/pkt_pkg.sv
`default_nettype none

package pkt_pkg;

	// {bin1, bin0} as sampled from the link
	typedef logic [1:0] line_sym_t;

	typedef logic [1:0] payload_t;
	typedef logic [1:0] queue_id_t;

	// first bit on the wire lands in qid[1]
	typedef struct packed {
		queue_id_t qid;
		payload_t  data;
	} packet_t;

	localparam line_sym_t SYM_IDLE   = 2'b00;
	localparam line_sym_t SYM_BIT1   = 2'b01;
	localparam line_sym_t SYM_BIT0   = 2'b10;
	localparam line_sym_t SYM_SPACER = 2'b11;

endpackage

`default_nettype wire

// File: hdl/pkt_switch_defines.svh
`ifndef PKT_SWITCH_DEFINES_SVH
`define PKT_SWITCH_DEFINES_SVH

`default_nettype none

// queue bank geometry
`define NUM_QUEUES 4
`define QUEUE_SLOTS 6

// one readout per this many packets
`define READ_INTERVAL 4

// edges with start_n low before the receiver arms
`define ARM_CYCLES 3

// drop counter width, wraps
`define DROP_W 7

`default_nettype wire

`endif

// File: hdl/pkt_switch_top.sv
`timescale 1ns/1ns
`include "pkt_switch_defines.svh"
`default_nettype none

module pkt_switch_top (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    start_n,
	input  logic                                    bin0,
	input  logic                                    bin1,
	output logic                                    packet_valid,
	output pkt_pkg::packet_t                        last_packet,
	output queue_pkg::occupancy_t  [`NUM_QUEUES-1:0] occupancy,
	output queue_pkg::drop_count_t [`NUM_QUEUES-1:0] drop_count,
	output logic                                    readout_valid,
	output pkt_pkg::queue_id_t                      readout_queue,
	output pkt_pkg::payload_t                       readout_data
);

	queue_bank_if bank ();

	symbol_receiver u_receiver (
		.clk          (clk),
		.rst          (rst),
		.start_n      (start_n),
		.sym          ({bin1, bin0}),
		.packet_valid (packet_valid),
		.last_packet  (last_packet)
	);

	// every queue sees every packet and matches its own index
	for (genvar q = 0; q < `NUM_QUEUES; q++) begin : g_queue
		slot_buffer #(
			.QUEUE_INDEX (q)
		) u_queue (
			.clk          (clk),
			.rst          (rst),
			.packet_valid (packet_valid),
			.packet       (last_packet),
			.bank         (bank.queue)
		);
	end

	read_scheduler u_scheduler (
		.clk           (clk),
		.rst           (rst),
		.packet_valid  (packet_valid),
		.bank          (bank.scheduler),
		.readout_valid (readout_valid),
		.readout_queue (readout_queue),
		.readout_data  (readout_data)
	);

	assign occupancy  = bank.occupancy;
	assign drop_count = bank.drops;

endmodule

`default_nettype wire

// File: hdl/queue_bank_if.sv
`timescale 1ns/1ns
`include "pkt_switch_defines.svh"
`default_nettype none

interface queue_bank_if;
	import queue_pkg::*;

	occupancy_t  [`NUM_QUEUES-1:0] occupancy;  // per queue fill level
	slot_t       [`NUM_QUEUES-1:0] oldest;     // slot at the old end
	logic        [`NUM_QUEUES-1:0] pop;        // one-cycle pulse
	drop_count_t [`NUM_QUEUES-1:0] drops;

	// each queue drives only its own element
	modport queue (
		output occupancy,
		output oldest,
		output drops,
		input  pop
	);

	modport scheduler (
		input  occupancy,
		input  oldest,
		output pop
	);

endinterface

`default_nettype wire

// File: hdl/queue_pkg.sv
`include "pkt_switch_defines.svh"
`default_nettype none

package queue_pkg;

	// empty flag set when the slot holds nothing
	typedef struct packed {
		logic              empty;
		pkt_pkg::payload_t data;
	} slot_t;

	// 0 to QUEUE_SLOTS
	typedef logic [2:0] occupancy_t;

	typedef logic [`DROP_W-1:0] drop_count_t;

	localparam slot_t EMPTY_SLOT = '{empty: 1'b1, data: 2'b00};

endpackage

`default_nettype wire

// File: hdl/read_scheduler.sv
`timescale 1ns/1ns
`include "pkt_switch_defines.svh"
`default_nettype none

module read_scheduler (
	input  logic                clk,
	input  logic                rst,
	input  logic                packet_valid,
	queue_bank_if.scheduler     bank,
	output logic                readout_valid,
	output pkt_pkg::queue_id_t  readout_queue,
	output pkt_pkg::payload_t   readout_data
);
	import pkt_pkg::*;
	import queue_pkg::*;

	localparam int CNT_W = $clog2(`READ_INTERVAL);

	logic [CNT_W-1:0]       pkt_cnt;
	logic                   last_of_group;
	logic                   read_req;  // one cycle after the Nth packet strobe
	queue_id_t              sel;
	queue_id_t              sel_q;
	logic [`NUM_QUEUES-1:0] pop_q;

	assign last_of_group = (pkt_cnt == CNT_W'(`READ_INTERVAL - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			pkt_cnt  <= '0;
			read_req <= 1'b0;
		end else begin
			read_req <= packet_valid && last_of_group;
			if (packet_valid) begin
				if (last_of_group) begin
					pkt_cnt <= '0;
				end else begin
					pkt_cnt <= pkt_cnt + 1'b1;
				end
			end
		end
	end

	// queue q wins at occupancy q+1 or more, higher q first, else queue 0
	always_comb begin
		sel = '0;
		for (int q = 1; q < `NUM_QUEUES; q++) begin
			if (bank.occupancy[q] >= occupancy_t'(q + 1)) begin
				sel = queue_id_t'(q);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pop_q         <= '0;
			readout_valid <= 1'b0;
		end else begin
			pop_q <= '0;
			if (read_req && bank.occupancy[sel] != '0) begin
				pop_q[sel] <= 1'b1;  // empty pick skips the readout
			end
			readout_valid <= |pop_q;
		end
	end

	// data taken on the edge the queue clears that slot
	always_ff @(posedge clk) begin
		if (read_req) begin
			sel_q <= sel;
		end
		if (|pop_q) begin
			readout_queue <= sel_q;
			readout_data  <= bank.oldest[sel_q].data;
		end
	end

	assign bank.pop = pop_q;

endmodule

`default_nettype wire

// File: hdl/slot_buffer.sv
`timescale 1ns/1ns
`include "pkt_switch_defines.svh"
`default_nettype none

module slot_buffer #(
	parameter int QUEUE_INDEX = 0
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  packet_valid,
	input  pkt_pkg::packet_t      packet,
	queue_bank_if.queue           bank
);
	import pkt_pkg::*;
	import queue_pkg::*;

	localparam int IDX_W = $clog2(`QUEUE_SLOTS);

	// slot 0 is the young end, slot QUEUE_SLOTS-1 the old end
	slot_t            slots [`QUEUE_SLOTS];
	occupancy_t       occ;
	logic [IDX_W-1:0] old_idx;
	drop_count_t      drops;
	logic             push;
	logic             full;

	assign push = packet_valid && (packet.qid == queue_id_t'(QUEUE_INDEX));
	assign full = !slots[`QUEUE_SLOTS-1].empty;

	// occupied slots stay packed from slot 0 upward
	always_comb begin
		occ     = '0;
		old_idx = '0;
		for (int i = 0; i < `QUEUE_SLOTS; i++) begin
			if (!slots[i].empty) begin
				occ     = occ + 1'b1;
				old_idx = IDX_W'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `QUEUE_SLOTS; i++) begin
				slots[i] <= EMPTY_SLOT;
			end
		end else if (push) begin
			for (int i = `QUEUE_SLOTS - 1; i > 0; i--) begin
				slots[i] <= slots[i-1];  // oldest falls out when full
			end
			slots[0] <= '{empty: 1'b0, data: packet.data};
		end else if (bank.pop[QUEUE_INDEX]) begin
			slots[old_idx] <= EMPTY_SLOT;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			drops <= '0;
		end else if (push && full) begin
			drops <= drops + 1'b1;
		end
	end

	assign bank.occupancy[QUEUE_INDEX] = occ;
	assign bank.oldest[QUEUE_INDEX]    = slots[old_idx];  // empty slot when occ is 0
	assign bank.drops[QUEUE_INDEX]     = drops;

endmodule

`default_nettype wire

// File: hdl/symbol_receiver.sv
`timescale 1ns/1ns
`include "pkt_switch_defines.svh"
`default_nettype none

module symbol_receiver (
	input  logic               clk,
	input  logic               rst,
	input  logic               start_n,
	input  pkt_pkg::line_sym_t sym,
	output logic               packet_valid,
	output pkt_pkg::packet_t   last_packet
);
	import pkt_pkg::*;

	localparam int ARM_W = $clog2(`ARM_CYCLES + 1);

	logic [ARM_W-1:0] arm_cnt;
	logic             armed;
	logic             need_spacer;  // last bit not yet followed by 11
	logic [1:0]       bit_cnt;
	logic [2:0]       shift_q;      // first three bits, msb first
	logic             bit_take;
	logic             bit_val;
	logic             last_bit;

	assign armed    = (arm_cnt == ARM_W'(`ARM_CYCLES));
	assign bit_take = armed && !need_spacer && (sym == SYM_BIT0 || sym == SYM_BIT1);
	assign bit_val  = (sym == SYM_BIT1);
	assign last_bit = (bit_cnt == 2'd3);

	always_ff @(posedge clk) begin
		if (rst) begin
			arm_cnt      <= '0;
			need_spacer  <= 1'b0;
			bit_cnt      <= '0;
			packet_valid <= 1'b0;
		end else begin
			packet_valid <= 1'b0;
			if (!armed) begin
				// start_n low edges need not be consecutive
				if (!start_n) begin
					arm_cnt <= arm_cnt + 1'b1;
				end
			end else if (sym == SYM_SPACER) begin
				need_spacer <= 1'b0;
			end else if (bit_take) begin
				bit_cnt <= bit_cnt + 1'b1;  // wraps to 0 after the 4th bit
				if (last_bit) begin
					packet_valid <= 1'b1;
					arm_cnt      <= '0;     // disarm
					need_spacer  <= 1'b0;
				end else begin
					need_spacer <= 1'b1;
				end
			end
		end
	end

	// 00 and unspaced repeats never reach here
	always_ff @(posedge clk) begin
		if (bit_take) begin
			if (last_bit) begin
				last_packet <= packet_t'({shift_q, bit_val});
			end else begin
				shift_q <= {shift_q[1:0], bit_val};
			end
		end
	end

endmodule

`default_nettype wire

// File: pkt_switch.f
+incdir+hdl
+incdir+verif
hdl/pkt_pkg.sv
hdl/queue_pkg.sv
hdl/queue_bank_if.sv
hdl/symbol_receiver.sv
hdl/slot_buffer.sv
hdl/read_scheduler.sv
hdl/pkt_switch_top.sv
verif/pkt_switch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --timescale 1ns/1ns --top-module pkt_switch_tb \
	-f pkt_switch.f -o pkt_switch_sim > "$LOG" 2>&1 \
	&& ./obj_dir/pkt_switch_sim >> "$LOG" 2>&1 \
	|| echo "build or run error" >> "$LOG"

cat "$LOG"
grep -q "Simulation failed" "$LOG" && exit 1
grep -q "Simulation completed successfully" "$LOG" || exit 1
exit 0

// File: verif/pkt_switch_model.svh
`ifndef PKT_SWITCH_MODEL_SVH
`define PKT_SWITCH_MODEL_SVH

payload_t    model_q [`NUM_QUEUES][`QUEUE_SLOTS];  // index 0 is the oldest entry
int          model_len [`NUM_QUEUES];
drop_count_t model_drops [`NUM_QUEUES];
int          model_pkts;
logic [31:0] lfsr_state = 32'h832e44ce;

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 32'h80200003;
	end
	return s >> 1;
endfunction

function automatic logic [1:0] rand_2bits();
	logic [1:0] r;
	r = '0;
	for (int i = 0; i < 2; i++) begin
		lfsr_state = lfsr_next(lfsr_state);  // one step per bit
		r = {r[0], lfsr_state[0]};
	end
	return r;
endfunction

// threshold rule, highest queue first
function automatic queue_id_t pick_queue();
	if (model_len[3] >= 4) begin
		return 2'd3;
	end else if (model_len[2] >= 3) begin
		return 2'd2;
	end else if (model_len[1] >= 2) begin
		return 2'd1;
	end
	return 2'd0;
endfunction

task automatic model_reset();
	for (int q = 0; q < `NUM_QUEUES; q++) begin
		model_len[q]   = 0;
		model_drops[q] = '0;
	end
	model_pkts = 0;
endtask

task automatic shift_out_oldest(input int q);
	for (int i = 0; i < `QUEUE_SLOTS - 1; i++) begin
		model_q[q][i] = model_q[q][i+1];
	end
	model_len[q]--;
endtask

task automatic model_push(input packet_t p);
	int q;
	q = int'(p.qid);
	if (model_len[q] == `QUEUE_SLOTS) begin
		shift_out_oldest(q);  // full queue loses its oldest
		model_drops[q] = model_drops[q] + 1'b1;
	end
	model_q[q][model_len[q]] = p.data;
	model_len[q]++;
	model_pkts++;
endtask

task automatic model_read(output logic due, output queue_id_t sel, output payload_t data);
	sel  = pick_queue();
	due  = (model_len[sel] != 0);
	data = model_q[sel][0];
	if (due) begin
		shift_out_oldest(int'(sel));
	end
endtask

task automatic drive_sym(input line_sym_t s);
	@(negedge clk);
	start_n      = 1'b1;
	{bin1, bin0} = s;
endtask

task automatic arm_link();
	repeat (`ARM_CYCLES) begin
		@(negedge clk);
		start_n      = 1'b0;
		{bin1, bin0} = SYM_IDLE;
	end
endtask

task automatic expect_packet(input packet_t p);
	sent_pkts[sent_cnt] = p;
	sent_cnt++;
endtask

`endif

// File: verif/pkt_switch_tb.sv
`timescale 1ns/1ns
`include "pkt_switch_defines.svh"
`default_nettype none

module pkt_switch_tb;
	import pkt_pkg::*;
	import queue_pkg::*;

	localparam int PKT_TIMEOUT    = 40;
	localparam int WINDOW_TIMEOUT = 10;
	localparam logic [47:0] MIX_SEQ = 48'h49AF_17CE_DB25;  // {qid, data} per nibble

	logic                          clk;
	logic                          rst;
	logic                          start_n;
	logic                          bin0;
	logic                          bin1;
	logic                          packet_valid;
	packet_t                       last_packet;
	occupancy_t  [`NUM_QUEUES-1:0] occupancy;
	drop_count_t [`NUM_QUEUES-1:0] drop_count;
	logic                          readout_valid;
	queue_id_t                     readout_queue;
	payload_t                      readout_data;

	packet_t   sent_pkts [512];
	int        sent_cnt = 0;
	int        rd_idx = 0;
	int        checks = 0;
	int        errors = 0;
	int        err_mark = 0;
	logic      rst_seen = 1'b1;  // rst as the DUT saw it on the last edge
	logic      after_rst = 1'b1;
	logic      window_open = 1'b0;
	int        since_pkt = 0;
	logic      rd_due = 1'b0;
	queue_id_t rd_q;
	payload_t  rd_d;
	packet_t   exp_pkt;

	`include "pkt_switch_model.svh"

	pkt_switch_top u_dut (
		.clk           (clk),
		.rst           (rst),
		.start_n       (start_n),
		.bin0          (bin0),
		.bin1          (bin1),
		.packet_valid  (packet_valid),
		.last_packet   (last_packet),
		.occupancy     (occupancy),
		.drop_count    (drop_count),
		.readout_valid (readout_valid),
		.readout_queue (readout_queue),
		.readout_data  (readout_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_packet(input string name, input packet_t got, input packet_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task automatic check_occupancy(input string name, input occupancy_t got, input occupancy_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
		end
	endtask

	task automatic check_drops(input string name, input drop_count_t got, input drop_count_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
		end
	endtask

	task automatic check_queue_id(input string name, input queue_id_t got, input queue_id_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
		end
	endtask

	task automatic check_payload(input string name, input payload_t got, input payload_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR t=%0t %s", $time, msg);
	endtask

	task automatic compare_state();
		for (int q = 0; q < `NUM_QUEUES; q++) begin
			check_occupancy($sformatf("occupancy[%0d]", q), occupancy[q], occupancy_t'(model_len[q]));
			check_drops($sformatf("drop_count[%0d]", q), drop_count[q], model_drops[q]);
		end
	endtask

	task automatic check_reset_state();
		for (int q = 0; q < `NUM_QUEUES; q++) begin
			check_occupancy($sformatf("occupancy[%0d]", q), occupancy[q], '0);
			check_drops($sformatf("drop_count[%0d]", q), drop_count[q], '0);
		end
		if (packet_valid || readout_valid) begin
			report_error("a strobe is high right after reset");
		end
	endtask

	always @(posedge clk) begin
		rst_seen <= rst;
	end

	// outputs only move on rising edges, so the falling edge sees them settled
	always @(negedge clk) begin
		if (rst_seen) begin
			model_reset();
			window_open = 1'b0;
			after_rst   = 1'b1;
		end else begin
			if (after_rst) begin
				check_reset_state();
				after_rst = 1'b0;
			end
			if (window_open) begin
				since_pkt++;
			end
			if (readout_valid && !(window_open && since_pkt == 3)) begin
				report_error("readout_valid pulsed outside the readout slot");
			end
			if (window_open && since_pkt == 1) begin
				compare_state();  // push has landed
				rd_due = 1'b0;
				if (model_pkts % `READ_INTERVAL == 0) begin
					model_read(rd_due, rd_q, rd_d);
				end
			end
			if (window_open && since_pkt == 3) begin
				if (rd_due && !readout_valid) begin
					report_error("no readout although a non-empty queue was picked");
				end else if (!rd_due && readout_valid) begin
					report_error("readout_valid pulsed with no readout expected");
				end else if (rd_due) begin
					check_queue_id("readout_queue", readout_queue, rd_q);
					check_payload("readout_data", readout_data, rd_d);
				end
				compare_state();
				window_open = 1'b0;
			end
			if (packet_valid) begin
				if (rd_idx >= sent_cnt) begin
					report_error("packet_valid pulsed with no packet sent on the link");
				end else begin
					exp_pkt = sent_pkts[rd_idx];
					rd_idx++;
					check_packet("last_packet", last_packet, exp_pkt);
					model_push(exp_pkt);
					window_open = 1'b1;
					since_pkt   = 0;
				end
			end
		end
	end

	task automatic abort_on_timeout(input string what);
		$display("ERROR t=%0t timed out waiting for %s", $time, what);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic wait_packet();
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			start_n      = 1'b1;
			{bin1, bin0} = SYM_IDLE;
			waited++;
		end while (!packet_valid && waited < PKT_TIMEOUT);
		if (!packet_valid) begin
			abort_on_timeout("packet_valid");
		end
	endtask

	// returns once the readout slot of the last packet has been checked
	task automatic settle();
		int waited;
		waited = 0;
		@(posedge clk);
		while (window_open && waited < WINDOW_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (window_open) begin
			abort_on_timeout("the readout slot to close");
		end
	endtask

	task automatic send_packet(input packet_t p);
		logic [3:0] bits;
		bits = p;
		expect_packet(p);
		arm_link();
		for (int i = 3; i >= 0; i--) begin
			drive_sym(bits[i] ? SYM_BIT1 : SYM_BIT0);  // msb first
			if (i != 0) begin
				drive_sym(SYM_SPACER);
			end
		end
		wait_packet();
		settle();
	endtask

	task automatic reset_dut();
		@(negedge clk);
		rst          = 1'b1;
		start_n      = 1'b1;
		{bin1, bin0} = SYM_IDLE;
		repeat (2) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic end_test(input int num, input string name);
		@(posedge clk);
		$display("test %0d %s: %0d errors", num, name, errors - err_mark);
	endtask

	initial begin
		logic [1:0] qid_r;
		logic [1:0] data_r;
		rst     = 1'b1;
		start_n = 1'b1;
		bin0    = 1'b0;
		bin1    = 1'b0;

		reset_dut();
		err_mark = errors;
		repeat (`ARM_CYCLES - 1) begin
			@(negedge clk);
			start_n = 1'b0;  // one low edge short of arming
		end
		drive_sym(SYM_BIT1);
		drive_sym(SYM_SPACER);
		drive_sym(SYM_BIT0);
		drive_sym(SYM_SPACER);
		drive_sym(SYM_BIT1);
		drive_sym(SYM_SPACER);
		drive_sym(SYM_BIT1);
		repeat (6) drive_sym(SYM_IDLE);
		end_test(1, "reset state and unarmed link");

		reset_dut();
		err_mark = errors;
		send_packet(packet_t'(4'b1001));
		send_packet(packet_t'(4'b0110));
		end_test(2, "armed packet, msb first");

		reset_dut();
		err_mark = errors;
		expect_packet(packet_t'(4'b1010));  // built from spaced bits only
		arm_link();
		drive_sym(SYM_BIT1);
		drive_sym(SYM_BIT1);
		drive_sym(SYM_SPACER);
		drive_sym(SYM_BIT0);
		drive_sym(SYM_IDLE);
		drive_sym(SYM_BIT0);
		drive_sym(SYM_SPACER);
		drive_sym(SYM_IDLE);
		drive_sym(SYM_BIT1);
		drive_sym(SYM_IDLE);
		drive_sym(SYM_SPACER);
		drive_sym(SYM_SPACER);
		drive_sym(SYM_BIT0);
		wait_packet();
		settle();
		end_test(3, "repeats and idles ignored");

		reset_dut();
		err_mark = errors;
		send_packet(packet_t'(4'b0001));
		for (int i = 0; i < 7; i++) begin
			send_packet(packet_t'({2'b11, i[1:0]}));  // last push overflows
		end
		end_test(4, "overflow and drop count");

		reset_dut();
		err_mark = errors;
		for (int i = 0; i < 12; i++) begin
			send_packet(packet_t'(MIX_SEQ[47 - 4*i -: 4]));
		end
		end_test(5, "threshold pick and empty pick");

		err_mark = errors;
		for (int i = 0; i < 200; i++) begin
			qid_r  = rand_2bits();
			data_r = rand_2bits();
			send_packet(packet_t'({qid_r, data_r}));
		end
		end_test(6, "random traffic");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
